/* eth_rx_pkg.sv */
`default_nettype none

package eth_rx_pkg;

   // Frame data types
   typedef logic [7:0]  byte_t;
   typedef logic [47:0] mac_addr_t;
   typedef logic [10:0] frame_len_t;
   typedef logic [31:0] crc_t;

   // Reflected CRC-32, LSB first on the wire
   localparam crc_t CRC_POLY = 32'hEDB8_8320;
   localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

   // Magic remainder after data plus a good FCS, normal bit order
   localparam crc_t CRC_RESIDUE = 32'hC704_DD7B;

   // MII framing
   localparam logic [3:0] PREAMBLE_NIBBLE = 4'h5;
   localparam byte_t      SFD_BYTE        = 8'hD5;

   localparam mac_addr_t BROADCAST_MAC = 48'hFFFF_FFFF_FFFF;

endpackage

`default_nettype wire

/* mii_byte_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface mii_byte_if;
   import eth_rx_pkg::*;

   // One byte per valid pulse, sof marks the first byte after the SFD
   logic  valid;
   byte_t data;
   logic  sof;
   // Pulsed alone once rx_dv has dropped
   logic  eof;

   modport src (output valid, output data, output sof, output eof);
   modport snk (input valid, input data, input sof, input eof);

endinterface

`default_nettype wire

/* mii_nibble_assembler.sv */
`timescale 1ns/1ns
`default_nettype none

module mii_nibble_assembler (
   input  logic       RX_CLK,
   input  logic       ETH_PHY_RESETN,
   input  logic       rx_dv,
   input  logic [3:0] rx_data,
   mii_byte_if.src    bytes
);
   import eth_rx_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_HUNT, S_DATA} state_t;

   state_t     state;
   logic       saw_five;
   logic       half;
   logic       first;
   logic [3:0] low_nib;

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state       <= S_IDLE;
         saw_five    <= 1'b0;
         half        <= 1'b0;
         first       <= 1'b0;
         bytes.valid <= 1'b0;
         bytes.sof   <= 1'b0;
         bytes.eof   <= 1'b0;
      end else begin
         bytes.valid <= 1'b0;
         bytes.sof   <= 1'b0;
         bytes.eof   <= 1'b0;
         case (state)
            S_IDLE: begin
               if (rx_dv) begin
                  state    <= S_HUNT;
                  saw_five <= (rx_data == PREAMBLE_NIBBLE);
               end
            end
            S_HUNT: begin
               // SFD is a 5 followed by a D
               if (!rx_dv) begin
                  state <= S_IDLE;
               end else if (saw_five && rx_data == SFD_BYTE[7:4]) begin
                  state <= S_DATA;
                  half  <= 1'b0;
                  first <= 1'b1;
               end else begin
                  saw_five <= (rx_data == PREAMBLE_NIBBLE);
               end
            end
            S_DATA: begin
               if (!rx_dv) begin
                  // Odd trailing nibble simply dropped here
                  state     <= S_IDLE;
                  bytes.eof <= 1'b1;
               end else if (!half) begin
                  half <= 1'b1;
               end else begin
                  half        <= 1'b0;
                  first       <= 1'b0;
                  bytes.valid <= 1'b1;
                  bytes.sof   <= first;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Low nibble arrives first
   always_ff @(posedge RX_CLK) begin
      if (state == S_DATA && rx_dv) begin
         if (!half) begin
            low_nib <= rx_data;
         end else begin
            bytes.data <= {rx_data, low_nib};
         end
      end
   end

endmodule

`default_nettype wire

/* eth_crc32.sv */
`timescale 1ns/1ns
`default_nettype none

module eth_crc32 (
   input  logic    RX_CLK,
   input  logic    ETH_PHY_RESETN,
   mii_byte_if.snk bytes,
   output logic    crc_good
);
   import eth_rx_pkg::*;

   crc_t crc_q;
   crc_t crc_rev;

   // Eight LSB-first shift steps of the reflected CRC
   function automatic crc_t fold_byte(crc_t crc_in, byte_t d);
      crc_t c;
      c = crc_in;
      for (int i = 0; i < 8; i++) begin
         if (c[0] ^ d[i]) begin
            c = (c >> 1) ^ CRC_POLY;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   // First byte is folded into a fresh seed
   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         crc_q <= CRC_INIT;
      end else if (bytes.valid) begin
         crc_q <= fold_byte(bytes.sof ? CRC_INIT : crc_q, bytes.data);
      end
   end

   // Register is reflected, residue is in normal order
   always_comb begin
      for (int i = 0; i < 32; i++) begin
         crc_rev[i] = crc_q[31-i];
      end
   end

   assign crc_good = (crc_rev == CRC_RESIDUE);

endmodule

`default_nettype wire

/* eth_frame_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module eth_frame_rx #(
   parameter eth_rx_pkg::mac_addr_t MAC_ADDR   = 48'h02_00_00_00_00_01,
   parameter int                    BUF_ADDR_W = 9
) (
   input  logic                   RX_CLK,
   input  logic                   ETH_PHY_RESETN,
   mii_byte_if.snk                bytes,
   input  logic                   crc_good,
   output logic                   wr_en,
   output eth_rx_pkg::frame_len_t wr_addr,
   output eth_rx_pkg::byte_t      wr_data,
   output logic                   rx_req,
   input  logic                   rx_ack,
   output eth_rx_pkg::frame_len_t rx_size,
   output logic                   crc_ok
);
   import eth_rx_pkg::*;

   localparam int BUF_BYTES = 4 << BUF_ADDR_W;

   logic       taking;
   frame_len_t byte_cnt;
   logic       own_match;
   logic       bc_match;
   logic       accept;
   logic       in_frame_byte;
   logic [2:0] addr_idx;

   // Only with the host handshake fully closed
   assign accept = !rx_req && !rx_ack;

   assign in_frame_byte = bytes.valid && (bytes.sof ? accept : taking);

   // Every taken frame starts at buffer address 0
   assign wr_addr  = bytes.sof ? '0 : byte_cnt;
   assign wr_data  = bytes.data;
   assign wr_en    = in_frame_byte && (int'(wr_addr) < BUF_BYTES);
   assign addr_idx = wr_addr[2:0];

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         taking    <= 1'b0;
         byte_cnt  <= '0;
         own_match <= 1'b0;
         bc_match  <= 1'b0;
         rx_req    <= 1'b0;
         rx_size   <= '0;
         crc_ok    <= 1'b0;
      end else begin
         if (in_frame_byte) begin
            taking   <= 1'b1;
            byte_cnt <= wr_addr + 1'b1;
            // Destination address, first byte on the wire is the MSB
            if (wr_addr < 6) begin
               own_match <= (bytes.sof || own_match) &&
                            (bytes.data == MAC_ADDR[8*(5-addr_idx) +: 8]);
               bc_match  <= (bytes.sof || bc_match) &&
                            (bytes.data == BROADCAST_MAC[8*(5-addr_idx) +: 8]);
            end
         end

         if (bytes.eof && taking) begin
            taking <= 1'b0;
            // Frames for other stations are just forgotten
            if (own_match || bc_match) begin
               rx_req  <= 1'b1;
               rx_size <= byte_cnt;
               crc_ok  <= crc_good;
            end
         end else if (rx_req && rx_ack) begin
            rx_req <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* rx_frame_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module rx_frame_buffer #(
   parameter int BUF_ADDR_W = 9
) (
   input  logic                   RX_CLK,
   input  logic                   wr_en,
   input  eth_rx_pkg::frame_len_t wr_addr,
   input  eth_rx_pkg::byte_t      wr_data,
   input  logic [BUF_ADDR_W-1:0]  rd_addr,
   output logic [31:0]            rd_data
);
   import eth_rx_pkg::*;

   logic [31:0] mem [2**BUF_ADDR_W];

   logic [BUF_ADDR_W-1:0] wr_word;
   logic [1:0]            wr_lane;

   // Byte n goes to word n/4, lane n mod 4
   assign wr_word = wr_addr[BUF_ADDR_W+1:2];
   assign wr_lane = wr_addr[1:0];

   always_ff @(posedge RX_CLK) begin
      if (wr_en) begin
         mem[wr_word][8*wr_lane +: 8] <= wr_data;
      end
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

/* eth_rx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module eth_rx_top #(
   parameter eth_rx_pkg::mac_addr_t MAC_ADDR   = 48'h02_00_00_00_00_01,
   parameter int                    BUF_ADDR_W = 9
) (
   input  logic                  RX_CLK,
   input  logic                  ETH_PHY_RESETN,
   input  logic                  rx_dv,
   input  logic [3:0]            rx_data,
   output logic                  rx_req,
   input  logic                  rx_ack,
   output logic [10:0]           rx_size,
   output logic                  crc_ok,
   input  logic [BUF_ADDR_W-1:0] rd_addr,
   output logic [31:0]           rd_data
);
   import eth_rx_pkg::*;

   logic       crc_good;
   logic       wr_en;
   frame_len_t wr_addr;
   byte_t      wr_data;

   mii_byte_if rx_bytes ();

   mii_nibble_assembler i_assembler (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .rx_dv          (rx_dv),
      .rx_data        (rx_data),
      .bytes          (rx_bytes.src)
   );

   eth_crc32 i_crc (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .bytes          (rx_bytes.snk),
      .crc_good       (crc_good)
   );

   // Filter, buffer addressing and host handshake
   eth_frame_rx #(
      .MAC_ADDR   (MAC_ADDR),
      .BUF_ADDR_W (BUF_ADDR_W)
   ) i_frame_rx (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .bytes          (rx_bytes.snk),
      .crc_good       (crc_good),
      .wr_en          (wr_en),
      .wr_addr        (wr_addr),
      .wr_data        (wr_data),
      .rx_req         (rx_req),
      .rx_ack         (rx_ack),
      .rx_size        (rx_size),
      .crc_ok         (crc_ok)
   );

   rx_frame_buffer #(
      .BUF_ADDR_W (BUF_ADDR_W)
   ) i_buffer (
      .RX_CLK  (RX_CLK),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

/* tb_eth_rx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_eth_rx_top;
   import eth_rx_pkg::*;

   localparam mac_addr_t OWN_MAC   = 48'h02_00_00_AB_CD_EF;
   localparam mac_addr_t OTHER_MAC = 48'h02_00_00_AB_CD_EE;
   localparam int        NUM_TESTS = 7;
   localparam int        GAP       = 12;
   localparam int        REQ_WAIT  = 32;

   // Destination 0 is own, 1 broadcast and 2 another station
   typedef struct packed {
      logic [1:0]  dest;
      logic [10:0] len;
      logic        corrupt;
      logic        during_hs;
      logic        exp_kept;
      logic        exp_crc_ok;
   } entry_t;

   logic        RX_CLK;
   logic        ETH_PHY_RESETN;
   logic        rx_dv;
   logic [3:0]  rx_data;
   logic        rx_req;
   logic        rx_ack;
   logic [10:0] rx_size;
   logic        crc_ok;
   logic [8:0]  rd_addr;
   logic [31:0] rd_data;

   entry_t tests [NUM_TESTS];
   byte_t  frame [2048];
   int     frame_len;
   int     err_cnt = 0;
   int     fail_cnt = 0;
   int     cycle_cnt = 0;
   int     cycle_limit = 0;

   eth_rx_top #(
      .MAC_ADDR   (OWN_MAC),
      .BUF_ADDR_W (9)
   ) i_eth_rx_top (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .rx_dv          (rx_dv),
      .rx_data        (rx_data),
      .rx_req         (rx_req),
      .rx_ack         (rx_ack),
      .rx_size        (rx_size),
      .crc_ok         (crc_ok),
      .rd_addr        (rd_addr),
      .rd_data        (rd_data)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #50 RX_CLK = ~RX_CLK;
   end

   always @(posedge RX_CLK) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Simulation FAILED");
         $finish;
      end
   end

   task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
      if (got !== want) begin
         $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, want);
         err_cnt++;
      end
   endtask

   // Inverted reflected CRC-32 over the first n bytes
   function automatic crc_t frame_fcs(int n);
      crc_t c;
      c = CRC_INIT;
      for (int i = 0; i < n; i++) begin
         c = c ^ {24'h0, frame[i]};
         for (int b = 0; b < 8; b++)
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
      end
      return ~c;
   endfunction

   task automatic build_frame(input entry_t e);
      mac_addr_t   dst;
      logic [63:0] hdr;
      crc_t        fcs;
      dst = (e.dest == 2'd0) ? OWN_MAC : ((e.dest == 2'd1) ? BROADCAST_MAC : OTHER_MAC);
      // Fixed source address and ethertype
      hdr = 64'h0211_2233_4455_88B5;
      for (int i = 0; i < 6; i++)
         frame[i] = dst[8*(5-i) +: 8];
      for (int i = 0; i < 8; i++)
         frame[6+i] = hdr[8*(7-i) +: 8];
      for (int i = 0; i < int'(e.len); i++)
         frame[14+i] = 8'($urandom());
      frame_len = 14 + int'(e.len);
      fcs = frame_fcs(frame_len);
      if (e.corrupt)
         fcs[5] = ~fcs[5];
      // FCS goes out least significant byte first
      for (int i = 0; i < 4; i++)
         frame[frame_len+i] = fcs[8*i +: 8];
      frame_len = frame_len + 4;
   endtask

   task automatic send_frame();
      // Preamble and SFD nibbles with the low nibble first
      for (int i = 0; i < 16; i++) begin
         @(negedge RX_CLK);
         rx_dv   = 1'b1;
         rx_data = (i == 15) ? SFD_BYTE[7:4] : PREAMBLE_NIBBLE;
      end
      for (int i = 0; i < 2 * frame_len; i++) begin
         @(negedge RX_CLK);
         rx_data = i[0] ? frame[i/2][7:4] : frame[i/2][3:0];
      end
      @(negedge RX_CLK);
      rx_dv   = 1'b0;
      rx_data = 4'h0;
      repeat (GAP - 1) @(negedge RX_CLK);
   endtask

   task automatic wait_req(input logic level, output logic seen);
      seen = 1'b0;
      for (int i = 0; i < REQ_WAIT && !seen; i++) begin
         @(negedge RX_CLK);
         seen = (rx_req == level);
      end
   endtask

   // One address per cycle and its data checked a cycle later
   task automatic read_back();
      int          words;
      logic [31:0] want;
      logic [31:0] mask;
      words = (frame_len + 3) / 4;
      for (int w = 0; w <= words; w++) begin
         @(negedge RX_CLK);
         if (w > 0) begin
            want = 32'h0;
            mask = 32'h0;
            for (int l = 0; l < 4; l++) begin
               if (4 * (w - 1) + l < frame_len) begin
                  want[8*l +: 8] = frame[4*(w-1) + l];
                  mask[8*l +: 8] = 8'hFF;
               end
            end
            check(rd_data & mask, want, $sformatf("buffer word %0d", w - 1));
         end
         if (w < words)
            rd_addr = 9'(w);
      end
   endtask

   task automatic finish_handshake();
      logic seen;
      @(negedge RX_CLK);
      rx_ack = 1'b1;
      wait_req(1'b0, seen);
      check(32'(seen), 32'd1, "rx_req drop after rx_ack");
      rx_ack = 1'b0;
   endtask

   initial begin
      int         budget;
      int         err_before;
      logic       seen;
      frame_len_t prev_size;
      void'($urandom(32'h62dd));
      ETH_PHY_RESETN = 1'b0;
      rx_dv          = 1'b0;
      rx_data        = 4'h0;
      rx_ack         = 1'b0;
      rd_addr        = 9'h0;
      prev_size      = '0;
      tests[0] = '{2'd0, 11'd46, 1'b0, 1'b0, 1'b1, 1'b1};
      tests[1] = '{2'd1, 11'd60, 1'b0, 1'b0, 1'b1, 1'b1};
      tests[2] = '{2'd2, 11'd46, 1'b0, 1'b0, 1'b0, 1'b0};
      tests[3] = '{2'd0, 11'd51, 1'b1, 1'b0, 1'b1, 1'b0};
      tests[4] = '{2'd0, 11'd46, 1'b0, 1'b0, 1'b1, 1'b1};
      // Arrives while the handshake of test 4 is still open
      tests[5] = '{2'd0, 11'd50, 1'b0, 1'b1, 1'b0, 1'b0};
      tests[6] = '{2'd0, 11'd63, 1'b0, 1'b0, 1'b1, 1'b1};
      budget = 0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         budget = budget + 16 + 2 * (int'(tests[t].len) + 18) + GAP;
         budget = budget + 2 * REQ_WAIT + (int'(tests[t].len) + 18) / 4 + 4;
      end
      cycle_limit = 2 * budget;
      repeat (4) @(negedge RX_CLK);
      ETH_PHY_RESETN = 1'b1;
      @(negedge RX_CLK);
      check(32'(rx_req), 32'd0, "rx_req after reset");
      check(32'(crc_ok), 32'd0, "crc_ok after reset");
      check(32'(rx_size), 32'd0, "rx_size after reset");
      for (int t = 0; t < NUM_TESTS; t++) begin
         err_before = err_cnt;
         build_frame(tests[t]);
         if (tests[t].during_hs)
            check(32'(rx_req), 32'd1, "rx_req open before frame");
         send_frame();
         if (tests[t].during_hs) begin
            check(32'(rx_size), 32'(prev_size), "rx_size held during handshake");
            finish_handshake();
         end
         wait_req(1'b1, seen);
         check(32'(seen), 32'(tests[t].exp_kept), "frame kept");
         if (seen) begin
            check(32'(rx_size), 32'(frame_len), "rx_size");
            check(32'(crc_ok), 32'(tests[t].exp_crc_ok), "crc_ok");
            read_back();
            prev_size = 11'(frame_len);
            if (t + 1 >= NUM_TESTS || !tests[t+1].during_hs)
               finish_handshake();
         end
         if (err_cnt == err_before) begin
            $display("Test %0d: dest %0d, %0d bytes: ok", t, tests[t].dest, frame_len);
         end else begin
            fail_cnt++;
            $display("Test %0d: dest %0d, %0d bytes: mismatch", t, tests[t].dest, frame_len);
         end
      end
      $display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
eth_rx_pkg.sv
mii_byte_if.sv
mii_nibble_assembler.sv
eth_crc32.sv
eth_frame_rx.sv
rx_frame_buffer.sv
eth_rx_top.sv
tb_eth_rx_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_eth_rx_top -f verilog.f
out=$(./obj_dir/Vtb_eth_rx_top)
echo "$out"
if echo "$out" | grep -q "Simulation PASSED"; then
   exit 0
fi
exit 1
